//--- Makefile
SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtext_term_tb: files.f $(SOURCES)
	verilator --binary --timing --assert --top-module text_term_tb -f files.f

sim.log: obj_dir/Vtext_term_tb
	./obj_dir/Vtext_term_tb > sim.log 2>&1 || true

run: sim.log
	@cat sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
+incdir+src
src/text_term_pkg.sv
src/key_queue.sv
src/cursor_counter.sv
src/key_cmd_fsm.sv
src/char_ram.sv
src/text_term_top.sv
verif/text_term_properties.sv
verif/text_term_tb.sv

//--- src/char_ram.sv
`timescale 1ns/10ps
`include "text_term_cfg.svh"

module char_ram (
    input  logic                 clk,
    input  logic                 wr_en,
    input  text_term_pkg::col_t  wr_col,
    input  text_term_pkg::row_t  wr_row,
    input  text_term_pkg::char_t wr_char,
    input  logic                 rd_en,
    input  text_term_pkg::col_t  rd_col,
    input  text_term_pkg::row_t  rd_row,
    output text_term_pkg::char_t rd_char
);
    import text_term_pkg::*;

    localparam int CELLS = `TT_CELLS;
    localparam int AW    = $clog2(CELLS);

    // row-major cell array
    char_t         mem [CELLS];
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;

    // row * cols + col
    assign wr_addr = AW'(wr_row) * AW'(`TT_COLS) + AW'(wr_col);
    assign rd_addr = AW'(rd_row) * AW'(`TT_COLS) + AW'(rd_col);

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_char;
        end
    end

    // read port, one cycle latency
    // output holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_char <= mem[rd_addr];
        end
    end

endmodule

//--- src/cursor_counter.sv
`timescale 1ns/10ps
`include "text_term_cfg.svh"

module cursor_counter (
    input  logic                   clk,
    input  logic                   rstn,
    input  text_term_pkg::cur_op_e cur_op,
    output text_term_pkg::col_t    cur_col,
    output text_term_pkg::row_t    cur_row,
    output logic                   sweep_last
);
    import text_term_pkg::*;

    // last valid indices
    localparam col_t LAST_COL = col_t'(`TT_COLS - 1);
    localparam row_t LAST_ROW = row_t'(`TT_ROWS - 1);

    // row step, bottom row wraps to the top
    function automatic row_t row_step(input row_t r);
        if (r == LAST_ROW) begin
            return '0;
        end
        return r + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cur_col <= '0;
            cur_row <= '0;
        end else begin
            case (cur_op)
                CUR_NEXT: begin
                    // line wrap at the last column
                    if (cur_col == LAST_COL) begin
                        cur_col <= '0;
                        cur_row <= row_step(cur_row);
                    end else begin
                        cur_col <= cur_col + 1'b1;
                    end
                end
                CUR_BACK: begin
                    // stuck at column 0, no reverse line wrap
                    if (cur_col != '0) begin
                        cur_col <= cur_col - 1'b1;
                    end
                end
                CUR_NEWLINE: begin
                    cur_col <= '0;
                    cur_row <= row_step(cur_row);
                end
                CUR_HOME: begin
                    cur_col <= '0;
                    cur_row <= '0;
                end
                default: begin
                    // hold
                    cur_col <= cur_col;
                    cur_row <= cur_row;
                end
            endcase
        end
    end

    // bottom right cell, end of the clear sweep
    // next CUR_NEXT from here lands on 0,0
    assign sweep_last = (cur_col == LAST_COL) && (cur_row == LAST_ROW);

endmodule

//--- src/key_cmd_fsm.sv
`timescale 1ns/10ps

module key_cmd_fsm (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   q_nonempty,
    input  text_term_pkg::char_t   q_char,
    input  logic                   sweep_last,
    output logic                   q_pop,
    output text_term_pkg::cur_op_e cur_op,
    output logic                   wr_en,
    output text_term_pkg::char_t   wr_char
);
    import text_term_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        BS_BLANK,
        CLEAR
    } state_e;

    // key class, decided at pop time
    typedef enum logic [2:0] {
        KIND_PRINT,
        KIND_BS,
        KIND_CR,
        KIND_FF,
        KIND_IGNORE
    } kind_e;

    // top of the printable range
    localparam char_t LAST_PRINT = 8'h7E;

    state_e state;
    state_e state_nxt;
    kind_e  kind_in;
    kind_e  kind_r;
    char_t  key_r;

    // classify the head entry
    always_comb begin
        if (q_char >= KEY_SPACE && q_char <= LAST_PRINT) begin
            kind_in = KIND_PRINT;
        end else if (q_char == KEY_BS) begin
            kind_in = KIND_BS;
        end else if (q_char == KEY_CR) begin
            kind_in = KIND_CR;
        end else if (q_char == KEY_FF) begin
            kind_in = KIND_FF;
        end else begin
            kind_in = KIND_IGNORE;
        end
    end

    // popped key and its class
    always_ff @(posedge clk) begin
        if (q_pop) begin
            key_r  <= q_char;
            kind_r <= kind_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // outputs and next state
    always_comb begin
        state_nxt = state;
        q_pop     = 1'b0;
        cur_op    = CUR_HOLD;
        wr_en     = 1'b0;
        wr_char   = KEY_SPACE;
        case (state)
            IDLE: begin
                // take one key whenever one is waiting
                if (q_nonempty) begin
                    q_pop     = 1'b1;
                    state_nxt = EXEC;
                end
            end
            EXEC: begin
                state_nxt = IDLE;
                case (kind_r)
                    KIND_PRINT: begin
                        wr_en   = 1'b1;
                        wr_char = key_r;
                        cur_op  = CUR_NEXT;
                    end
                    KIND_BS: begin
                        // step back first, blank next cycle
                        cur_op    = CUR_BACK;
                        state_nxt = BS_BLANK;
                    end
                    KIND_CR: cur_op = CUR_NEWLINE;
                    KIND_FF: begin
                        cur_op    = CUR_HOME;
                        state_nxt = CLEAR;
                    end
                    default: cur_op = CUR_HOLD;
                endcase
            end
            BS_BLANK: begin
                // cursor already moved back
                wr_en     = 1'b1;
                state_nxt = IDLE;
            end
            CLEAR: begin
                // one space per cell, starting at 0,0
                wr_en  = 1'b1;
                cur_op = CUR_NEXT;
                if (sweep_last) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

endmodule

//--- src/key_queue.sv
`timescale 1ns/10ps
`include "text_term_cfg.svh"

module key_queue (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 key_valid,
    input  text_term_pkg::char_t key_char,
    input  logic                 q_pop,
    output logic                 q_nonempty,
    output text_term_pkg::char_t q_char,
    output logic                 key_credit
);
    import text_term_pkg::*;

    localparam int DEPTH = `TT_KEY_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    // circular storage
    char_t           mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;

    // pointer step with wrap at DEPTH-1
    // (depth need not be a power of two)
    function automatic logic [PW-1:0] ptr_step(input logic [PW-1:0] p);
        if (p == PW'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // payload store
    always_ff @(posedge clk) begin
        if (key_valid) begin
            mem[wr_ptr] <= key_char;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            key_credit <= 1'b0;
        end else begin
            if (key_valid) begin
                wr_ptr <= ptr_step(wr_ptr);
            end
            if (q_pop) begin
                rd_ptr <= ptr_step(rd_ptr);
            end
            // occupancy unchanged when push and pop coincide
            case ({key_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per pop a cycle later
            key_credit <= q_pop;
        end
    end

    // head of queue
    assign q_nonempty = (count != '0);
    assign q_char     = mem[rd_ptr];

endmodule

//--- src/text_term_cfg.svh
`ifndef TEXT_TERM_CFG_SVH
`define TEXT_TERM_CFG_SVH

// character grid geometry
// columns per row
`define TT_COLS 70

// rows on screen
`define TT_ROWS 30

// total cells, also the length of a clear sweep
`define TT_CELLS (`TT_COLS * `TT_ROWS)

// key queue entries
// the sender starts with this many credits
`define TT_KEY_DEPTH 4

`endif

//--- src/text_term_pkg.sv
package text_term_pkg;

    // one character code, ascii
    typedef logic [7:0] char_t;

    // column index, 0 to TT_COLS-1
    typedef logic [6:0] col_t;

    // row index, 0 to TT_ROWS-1
    typedef logic [4:0] row_t;

    // cursor operation from the fsm to the counter
    // applied on the next clock edge
    typedef enum logic [2:0] {
        CUR_HOLD,
        CUR_NEXT,
        CUR_BACK,
        CUR_NEWLINE,
        CUR_HOME
    } cur_op_e;

    // key codes with special handling
    localparam char_t KEY_BS    = 8'h08;
    localparam char_t KEY_FF    = 8'h0C;
    localparam char_t KEY_CR    = 8'h0D;

    // blank cell, also the first printable code
    localparam char_t KEY_SPACE = 8'h20;

endpackage

//--- src/text_term_top.sv
`timescale 1ns/10ps

module text_term_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 key_valid,
    input  text_term_pkg::char_t key_char,
    output logic                 key_credit,
    input  logic                 rd_en,
    input  text_term_pkg::col_t  rd_col,
    input  text_term_pkg::row_t  rd_row,
    output text_term_pkg::char_t rd_char,
    output text_term_pkg::col_t  cur_col,
    output text_term_pkg::row_t  cur_row
);
    import text_term_pkg::*;

    // queue to fsm
    logic    q_nonempty;
    logic    q_pop;
    char_t   q_char;

    // fsm to counter and ram
    cur_op_e cur_op;
    logic    sweep_last;
    logic    wr_en;
    char_t   wr_char;

    key_queue u_key_queue (
        .clk        (clk),
        .rstn       (rstn),
        .key_valid  (key_valid),
        .key_char   (key_char),
        .q_pop      (q_pop),
        .q_nonempty (q_nonempty),
        .q_char     (q_char),
        .key_credit (key_credit)
    );

    key_cmd_fsm u_cmd_fsm (
        .clk        (clk),
        .rstn       (rstn),
        .q_nonempty (q_nonempty),
        .q_char     (q_char),
        .sweep_last (sweep_last),
        .q_pop      (q_pop),
        .cur_op     (cur_op),
        .wr_en      (wr_en),
        .wr_char    (wr_char)
    );

    cursor_counter u_cursor (
        .clk        (clk),
        .rstn       (rstn),
        .cur_op     (cur_op),
        .cur_col    (cur_col),
        .cur_row    (cur_row),
        .sweep_last (sweep_last)
    );

    // write address is the live cursor
    char_ram u_char_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_col  (cur_col),
        .wr_row  (cur_row),
        .wr_char (wr_char),
        .rd_en   (rd_en),
        .rd_col  (rd_col),
        .rd_row  (rd_row),
        .rd_char (rd_char)
    );

endmodule

//--- verif/text_term_properties.sv
`timescale 1ns/10ps
`include "text_term_cfg.svh"

module text_term_properties (
    input logic                 clk,
    input logic                 rstn,
    input logic                 key_valid,
    input logic                 key_credit,
    input logic                 wr_en,
    input text_term_pkg::col_t  cur_col,
    input text_term_pkg::row_t  cur_row,
    input logic                 rd_en,
    input text_term_pkg::char_t rd_char
);
    import text_term_pkg::*;

    // credits the sender holds, rebuilt from the link
    int   credits;
    // reset was already low on the previous edge
    logic rst_prev;

    always_ff @(posedge clk) begin
        rst_prev <= !rstn;
        if (!rstn) begin
            credits <= `TT_KEY_DEPTH;
        end else begin
            credits <= credits - int'(key_valid) + int'(key_credit);
        end
    end

    // a push spends a credit the sender really has
    a_push_credit: assert property (@(posedge clk) disable iff (!rstn)
        key_valid |-> (credits > 0) && (credits <= `TT_KEY_DEPTH))
        else $error("key pushed without an outstanding credit");

    // cursor never leaves the grid
    a_cursor_range: assert property (@(posedge clk) disable iff (!rstn)
        (int'(cur_col) < `TT_COLS) && (int'(cur_row) < `TT_ROWS))
        else $error("cursor outside the character grid");

    // quiet outputs once reset has been seen on an edge
    a_reset_quiet: assert property (@(posedge clk)
        (!rstn && rst_prev) |-> (!wr_en && !key_credit))
        else $error("write or credit active during reset");

    // read register moves only after a read request
    a_read_hold: assert property (@(posedge clk) disable iff (!rstn)
        !$past(rd_en) |-> $stable(rd_char))
        else $error("read data changed without a read request");

endmodule

bind text_term_top text_term_properties u_props (
    .clk        (clk),
    .rstn       (rstn),
    .key_valid  (key_valid),
    .key_credit (key_credit),
    .wr_en      (wr_en),
    .cur_col    (cur_col),
    .cur_row    (cur_row),
    .rd_en      (rd_en),
    .rd_char    (rd_char)
);

//--- verif/text_term_tb.sv
`timescale 1ns/10ps
`include "text_term_cfg.svh"

module text_term_tb;
    import text_term_pkg::*;

    // three clear sweeps plus the rest of the tests
    localparam int MAX_CYCLES = 3 * `TT_CELLS + 13700;

    logic  clk;
    logic  rstn;
    logic  key_valid;
    char_t key_char;
    logic  key_credit;
    logic  rd_en;
    col_t  rd_col;
    row_t  rd_row;
    char_t rd_char;
    col_t  cur_col;
    row_t  cur_row;

    // reference grid and cursor
    char_t grid_model [`TT_ROWS][`TT_COLS];
    int    mcol;
    int    mrow;
    // sender credit bookkeeping
    int    pushes_sent;
    int    credits_seen;
    int    errors;
    int    checks;
    int    cycles;

    text_term_top u_dut (
        .clk        (clk),
        .rstn       (rstn),
        .key_valid  (key_valid),
        .key_char   (key_char),
        .key_credit (key_credit),
        .rd_en      (rd_en),
        .rd_col     (rd_col),
        .rd_row     (rd_row),
        .rd_char    (rd_char),
        .cur_col    (cur_col),
        .cur_row    (cur_row)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // credit pulses and the run limit
    always @(posedge clk) begin
        cycles++;
        if (rstn && key_credit) begin
            credits_seen++;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped: cycle limit of %0d reached", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_char(input string name, input char_t exp, input char_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected 8'h%02h, got 8'h%02h", name, exp, act);
        end
    endtask

    task automatic check_cursor(input string name, input col_t exp_col, input row_t exp_row,
                                input col_t act_col, input row_t act_row);
        checks++;
        if (exp_col !== act_col || exp_row !== act_row) begin
            errors++;
            $display("FAIL %s: expected cursor %0d,%0d, got %0d,%0d",
                     name, exp_col, exp_row, act_col, act_row);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAIL %s: expected %0d, got %0d", name, exp, act);
        end
    endtask

    // terminal rules applied to the reference grid and cursor
    function automatic void apply_model(input char_t c);
        if (c >= KEY_SPACE && c <= 8'h7E) begin
            grid_model[mrow][mcol] = c;
            mcol++;
            if (mcol == `TT_COLS) begin
                mcol = 0;
                mrow = (mrow + 1) % `TT_ROWS;
            end
        end else if (c == KEY_BS) begin
            if (mcol != 0) begin
                mcol--;
            end
            grid_model[mrow][mcol] = KEY_SPACE;
        end else if (c == KEY_CR) begin
            mcol = 0;
            mrow = (mrow + 1) % `TT_ROWS;
        end else if (c == KEY_FF) begin
            for (int r = 0; r < `TT_ROWS; r++) begin
                for (int k = 0; k < `TT_COLS; k++) begin
                    grid_model[r][k] = KEY_SPACE;
                end
            end
            mcol = 0;
            mrow = 0;
        end
    endfunction

    // one push that stalls while no credit is left
    task automatic push_key(input char_t c);
        while (pushes_sent - credits_seen >= `TT_KEY_DEPTH) begin
            @(negedge clk);
        end
        key_valid = 1'b1;
        key_char  = c;
        pushes_sent++;
        @(negedge clk);
        key_valid = 1'b0;
    endtask

    task automatic wait_credits(input string name);
        int waited;
        waited = 0;
        while (credits_seen < pushes_sent && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (credits_seen < pushes_sent) begin
            errors++;
            $display("%s: credit pulse did not come back from the queue", name);
        end
    endtask

    // send and execute a key then compare the cursor
    task automatic type_key(input string name, input char_t c);
        int settle;
        settle = (c == KEY_FF) ? `TT_CELLS + 3 : 3;
        push_key(c);
        wait_credits(name);
        repeat (settle) @(negedge clk);
        apply_model(c);
        check_cursor(name, col_t'(mcol), row_t'(mrow), cur_col, cur_row);
    endtask

    task automatic check_cell(input string name, input int c, input int r);
        string where;
        where  = $sformatf("%s cell %0d,%0d", name, c, r);
        rd_en  = 1'b1;
        rd_col = col_t'(c);
        rd_row = row_t'(r);
        @(negedge clk);
        rd_en  = 1'b0;
        check_char(where, grid_model[r][c], rd_char);
    endtask

    task automatic test_reset_clear();
        check_cursor("reset_clear", '0, '0, cur_col, cur_row);
        type_key("reset_clear", KEY_FF);
        check_cell("reset_clear", 0, 0);
        check_cell("reset_clear", `TT_COLS - 1, 0);
        check_cell("reset_clear", 0, `TT_ROWS - 1);
        check_cell("reset_clear", `TT_COLS - 1, `TT_ROWS - 1);
        repeat (40) begin
            check_cell("reset_clear", int'($urandom % `TT_COLS), int'($urandom % `TT_ROWS));
        end
    endtask

    // longer than one line so the cursor wraps
    task automatic test_printable_wrap();
        repeat (`TT_COLS + 10) begin
            type_key("printable_wrap", char_t'(32'h20 + ($urandom % 95)));
        end
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < `TT_COLS; k++) begin
                check_cell("printable_wrap", k, r);
            end
        end
    endtask

    task automatic test_bs_enter();
        int row;
        type_key("bs_enter", KEY_CR);
        row = mrow;
        type_key("bs_enter", 8'h61);
        type_key("bs_enter", 8'h62);
        type_key("bs_enter", KEY_BS);
        check_cell("bs_enter", 0, row);
        check_cell("bs_enter", 1, row);
        // second one reaches column 0 and third one saturates there
        type_key("bs_enter", KEY_BS);
        type_key("bs_enter", KEY_BS);
        check_cell("bs_enter", 0, row);
        while (mrow != `TT_ROWS - 1) begin
            type_key("bs_enter", KEY_CR);
        end
        // wrap from the bottom row
        type_key("bs_enter", KEY_CR);
        check_cursor("bs_enter", '0, '0, cur_col, cur_row);
    endtask

    task automatic test_ignored();
        type_key("ignored", 8'h01);
        type_key("ignored", 8'h1B);
        type_key("ignored", 8'h7F);
        type_key("ignored", 8'h80);
        type_key("ignored", 8'hFF);
        for (int k = 0; k < `TT_COLS; k++) begin
            check_cell("ignored", k, mrow);
        end
    endtask

    // back to back keys paced only by the credits
    task automatic test_credit_flow();
        int start;
        int col0;
        int row0;
        start = credits_seen;
        col0  = mcol;
        row0  = mrow;
        for (int i = 0; i < 12; i++) begin
            push_key(char_t'(32'h41 + i));
        end
        wait_credits("credit_flow");
        repeat (3) @(negedge clk);
        check_count("credit_flow", 12, credits_seen - start);
        for (int i = 0; i < 12; i++) begin
            apply_model(char_t'(32'h41 + i));
        end
        check_cursor("credit_flow", col_t'(mcol), row_t'(mrow), cur_col, cur_row);
        for (int i = 0; i < 12; i++) begin
            check_cell("credit_flow", col0 + i, row0);
        end
    endtask

    initial begin
        void'($urandom(32'hae673ecf));
        rstn         = 1'b0;
        key_valid    = 1'b0;
        key_char     = '0;
        rd_en        = 1'b0;
        rd_col       = '0;
        rd_row       = '0;
        mcol         = 0;
        mrow         = 0;
        pushes_sent  = 0;
        credits_seen = 0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        test_reset_clear();
        test_printable_wrap();
        test_bs_enter();
        test_ignored();
        test_credit_flow();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
